// File: files.f
verilog/ice51_pkg.sv
verilog/exec_if.sv
verilog/uart_loader.sv
verilog/cpu_control.sv
verilog/cpu_datapath.sv
verilog/uart_tx.sv
verilog/ice51_top.sv
tb/tb_ice51.sv

// File: run.sh
#!/bin/sh
# build with verilator, then look for the pass line in the simulator output
cd "$(dirname "$0")" &&
verilator --binary --timing -sv -Wno-fatal -f files.f --top-module tb_ice51 -o sim_tb &&
./obj_dir/sim_tb | tee /dev/stderr | grep -q "SIMULATION PASSED" &&
echo "run ok" || { echo "run not ok"; exit 1; }

// File: tb/tb_ice51.sv
`timescale 1ns/10ps

module tb_ice51 import ice51_pkg::*; ();

   localparam int TIMEOUT = (LOAD_BYTES + 64) * 11 * (BAUD_DIV + 1);

   logic               i_clk = 1'b0;
   logic               i_nrst;
   logic               i_uart_rx;
   byte_t              code_rd;
   logic               o_uart_tx;
   logic               o_code_wr;
   logic [CODE_AW-1:0] o_code_addr;
   byte_t              o_code_data;

   byte_t       mem [LOAD_BYTES];     // external code memory
   byte_t       prog [LOAD_BYTES];    // program image sent by the loader
   byte_t       exp_q [$];
   byte_t       got_q [$];
   int          seg_first [4];
   int          seg_n [4];
   int          pc_b;
   int          errors;
   int          wr_count;
   int          cycles;
   logic [31:0] lcg;
   byte_t       m_acc;                // model accumulator and carry
   logic        m_c;

   ice51_top dut0 (
      .i_clk(i_clk), .i_nrst(i_nrst), .i_uart_rx(i_uart_rx), .i_code_data(code_rd),
      .o_uart_tx(o_uart_tx), .o_code_wr(o_code_wr), .o_code_addr(o_code_addr),
      .o_code_data(o_code_data)
   );

   always #5 i_clk = ~i_clk;

   always @(posedge i_clk) begin
      if (o_code_wr === 1'b1) mem[o_code_addr] <= o_code_data;
      code_rd <= mem[o_code_addr];     // synchronous read
   end

   always @(posedge i_clk) begin
      cycles++;
      if (cycles >= TIMEOUT) begin
         $display("timeout, the run did not finish within %0d cycles", TIMEOUT);
         $display("SIMULATION FAILED");
         $finish;
      end
   end

   task check(input string name, input logic [31:0] got, input logic [31:0] exp);
      if (got !== exp) begin
         $display("CHECK FAILED %s got %h expected %h", name, got, exp);
         errors++;
      end
   endtask

   function byte_t next_rand();
      lcg = lcg * 32'd1103515245 + 32'd12345;
      return lcg[23:16];
   endfunction

   //////////////////////////////////////////////////////////////////////
   // program image and expected bytes

   task put(input byte_t b);
      prog[pc_b] = b;
      pc_b++;
   endtask

   // save A in r7, poll status until idle, restore A and write tx data
   task send_seq();
      put(OP_MOV_RA | 8'd7);
      put(OP_MOV_DPTR); put(ADDR_TX_STAT[15:8]); put(ADDR_TX_STAT[7:0]);
      put(OP_MOVX_AD);
      put(OP_JNZ); put(8'hFD);                         // back to the movx
      put(OP_MOV_AR | 8'd7);
      put(OP_MOV_DPTR); put(ADDR_TX_DATA[15:8]); put(ADDR_TX_DATA[7:0]);
      put(OP_MOVX_DA);
   endtask

   task send_acc();
      send_seq();
      exp_q.push_back(m_acc);
   endtask

   task mov_imm(input byte_t imm);
      put(OP_MOV_AI); put(imm);
      m_acc = imm;
   endtask

   task alu(input byte_t op, input byte_t imm);
      int s;
      put(op); put(imm);
      if (op == OP_ADD_AI || op == OP_ADDC_AI) begin
         s = int'(m_acc) + int'(imm);
         if (op == OP_ADDC_AI && m_c) s++;
         m_acc = byte_t'(s % 256);
         m_c = (s > 255);                              // carry out of the byte
      end else if (op == OP_ANL_AI) m_acc = m_acc & imm;
      else m_acc = m_acc ^ imm;
   endtask

   // jcc picks one of two markers and one shared send follows
   task branch_case(input byte_t op, input byte_t k);
      logic tk;
      tk = (op == OP_SJMP) || (op == OP_JZ && m_acc == 0) || (op == OP_JNZ && m_acc != 0)
           || (op == OP_JC && m_c) || (op == OP_JNC && !m_c);
      put(op); put(8'd4);
      put(OP_MOV_AI); put(8'hB0 + k);                  // untaken path
      put(OP_SJMP); put(8'd2);
      put(OP_MOV_AI); put(8'hC0 + k);                  // taken path
      m_acc = tk ? 8'hC0 + k : 8'hB0 + k;
      send_acc();
   endtask

   task build_program();
      byte_t r;
      int    i;
      m_acc = 0;
      m_c = 0;
      seg_first[0] = exp_q.size();
      mov_imm(8'h3C); send_acc();
      alu(OP_ADD_AI, 8'hD0); send_acc();               // sets carry
      alu(OP_ADDC_AI, 8'h01); send_acc();
      r = next_rand();
      alu(OP_ADDC_AI, r); send_acc();
      alu(OP_ANL_AI, 8'h7A); send_acc();
      alu(OP_XRL_AI, 8'hFF); send_acc();
      put(OP_INC_A); m_acc++; send_acc();
      put(OP_DEC_A); put(OP_DEC_A); m_acc -= 2; send_acc();
      put(OP_CLR_A); m_acc = 0; send_acc();
      mov_imm(8'h5A); put(OP_MOV_RA | 8'd3); put(OP_CLR_A); put(OP_MOV_AR | 8'd3);
      send_acc();
      seg_n[0] = exp_q.size() - seg_first[0];
      seg_first[1] = exp_q.size();
      branch_case(OP_SJMP, 0);
      mov_imm(8'h00); branch_case(OP_JZ, 1);
      mov_imm(8'h05); branch_case(OP_JZ, 2);
      mov_imm(8'h00); branch_case(OP_JNZ, 3);
      mov_imm(8'h05); branch_case(OP_JNZ, 4);
      mov_imm(8'hFF); alu(OP_ADD_AI, 8'h01); branch_case(OP_JC, 5);
      mov_imm(8'h07); alu(OP_ADD_AI, 8'h00); branch_case(OP_JC, 6);
      mov_imm(8'hFF); alu(OP_ADD_AI, 8'h01); branch_case(OP_JNC, 7);
      mov_imm(8'h07); alu(OP_ADD_AI, 8'h00); branch_case(OP_JNC, 8);
      seg_n[1] = exp_q.size() - seg_first[1];
      seg_first[2] = exp_q.size();
      for (i = 0; i < 2; i++) begin
         mov_imm(i == 0 ? 8'd5 : 8'd1);
         put(OP_MOV_RA | 8'd2); put(OP_CLR_A);
         put(OP_INC_A); put(OP_DJNZ_R | 8'd2); put(8'hFD);   // inc a, djnz r2
         send_acc();
      end
      seg_n[2] = exp_q.size() - seg_first[2];
      seg_first[3] = exp_q.size();
      for (i = 0; i < 4; i++) begin
         r = next_rand();
         mov_imm(r); send_acc();
      end
      seg_n[3] = exp_q.size() - seg_first[3];
      put(OP_SJMP); put(8'hFE);                        // park here
      while (pc_b < LOAD_BYTES) begin
         r = next_rand();
         put(8'hA0 | (r & 8'h0F));                     // unused opcodes that are never reached
      end
   endtask

   //////////////////////////////////////////////////////////////////////
   // serial driver and monitor

   task drive_bit(input logic v);
      @(posedge i_clk);
      i_uart_rx <= v;
      repeat (BAUD_DIV) @(posedge i_clk);
   endtask

   task send_byte(input byte_t b);
      int i;
      drive_bit(1'b0);
      for (i = 0; i < 8; i++) drive_bit(b[i]);         // lsb first
      drive_bit(1'b1);
   endtask

   task automatic recv_byte(output byte_t b);
      int i;
      b = 0;
      @(negedge i_clk);
      while (o_uart_tx !== 1'b0) @(negedge i_clk);
      repeat (BAUD_DIV / 2) @(negedge i_clk);          // middle of start bit
      for (i = 0; i < 8; i++) begin
         repeat (BAUD_DIV + 1) @(negedge i_clk);
         b = {b[6:0], o_uart_tx};                      // msb first
      end
      repeat (BAUD_DIV + 1) @(negedge i_clk);
      if (o_uart_tx !== 1'b1) begin
         $display("stop bit on the serial output is not high");
         errors++;
      end
   endtask

   initial begin : serial_monitor
      byte_t b;
      wait (i_nrst === 1'b0);
      wait (i_nrst === 1'b1);
      forever begin
         recv_byte(b);
         got_q.push_back(b);
      end
   end

   always @(negedge i_clk) begin
      if (i_nrst === 1'b1 && o_code_wr === 1'b1) begin
         if (wr_count < LOAD_BYTES) begin
            check("o_code_addr", o_code_addr, wr_count);
            check("o_code_data", o_code_data, prog[wr_count]);
         end
         wr_count++;
      end
   end

   //////////////////////////////////////////////////////////////////////
   // directed tests

   task test_reset();
      repeat (4) begin
         @(negedge i_clk);
         check("o_uart_tx", o_uart_tx, 1);
         check("o_code_wr", o_code_wr, 0);
      end
      @(posedge i_clk) i_nrst <= 1'b1;
      @(negedge i_clk);
      check("o_uart_tx", o_uart_tx, 1);
      check("o_code_wr", o_code_wr, 0);
   endtask

   task test_load();
      int i;
      for (i = 0; i < LOAD_BYTES; i++) send_byte(prog[i]);
      repeat (4) @(negedge i_clk);
      check("code write count", wr_count, LOAD_BYTES);
      for (i = 0; i < LOAD_BYTES; i++) check($sformatf("mem[%0d]", i), mem[i], prog[i]);
      send_byte(8'h5A);                                // one byte past the image, not stored
   endtask

   task check_segment(input string name, input int k);
      int i;
      while (got_q.size() < seg_first[k] + seg_n[k]) @(negedge i_clk);
      for (i = seg_first[k]; i < seg_first[k] + seg_n[k]; i++)
         check($sformatf("%s o_uart_tx byte %0d", name, i), got_q[i], exp_q[i]);
   endtask

   initial begin
      errors = 0;
      wr_count = 0;
      cycles = 0;
      pc_b = 0;
      lcg = 32'h854d;
      i_uart_rx = 1'b1;
      code_rd = '0;
      i_nrst = 1'b1;
      #1 i_nrst = 1'b0;                                // falling edge for the async reset
      build_program();
      test_reset();
      test_load();
      check_segment("arith", 0);
      check_segment("branch", 1);
      check_segment("loop", 2);
      check_segment("status", 3);
      repeat (11 * (BAUD_DIV + 1)) @(negedge i_clk);   // a frame of quiet line
      check("received byte count", got_q.size(), exp_q.size());
      check("code write count", wr_count, LOAD_BYTES);
      $display("errors: %0d", errors);
      if (errors == 0) begin
         $display("SIMULATION PASSED");
      end else begin
         $display("SIMULATION FAILED");
      end
      $finish;
   end

endmodule

// File: verilog/ice51_top.sv
`timescale 1ns/10ps

module ice51_top import ice51_pkg::*; (
   input  logic               i_clk,
   input  logic               i_nrst,
   input  logic               i_uart_rx,
   input  byte_t              i_code_data,
   output logic               o_uart_tx,
   output logic               o_code_wr,
   output logic [CODE_AW-1:0] o_code_addr,
   output byte_t              o_code_data
);

   exec_if             exec_bus ();
   logic               load_done;
   logic [CODE_AW-1:0] fetch_addr;
   logic               tx_start;
   byte_t              tx_data;
   logic               tx_busy;

   uart_loader loader0 (
      .i_clk(i_clk), .i_nrst(i_nrst), .i_uart_rx(i_uart_rx),
      .i_fetch_addr(fetch_addr), .o_code_wr(o_code_wr),
      .o_code_addr(o_code_addr), .o_code_data(o_code_data), .o_load_done(load_done)
   );

   cpu_control ctrl0 (
      .i_clk(i_clk), .i_nrst(i_nrst), .i_load_done(load_done),
      .i_code_data(i_code_data), .o_fetch_addr(fetch_addr), .exec_bus(exec_bus)
   );

   cpu_datapath dp0 (
      .i_clk(i_clk), .i_nrst(i_nrst), .i_tx_busy(tx_busy),
      .exec_bus(exec_bus), .o_tx_start(tx_start), .o_tx_data(tx_data)
   );

   uart_tx tx0 (
      .i_clk(i_clk), .i_nrst(i_nrst), .i_tx_start(tx_start),
      .i_tx_data(tx_data), .o_uart_tx(o_uart_tx), .o_tx_busy(tx_busy)
   );

endmodule

// File: verilog/uart_tx.sv
`timescale 1ns/10ps

module uart_tx import ice51_pkg::*; (
   input  logic  i_clk,
   input  logic  i_nrst,
   input  logic  i_tx_start,
   input  byte_t i_tx_data,
   output logic  o_uart_tx,
   output logic  o_tx_busy
);

   typedef enum logic [1:0] {TX_IDLE, TX_START, TX_SEND} tx_state_t;

   tx_state_t         state;
   logic [BAUD_W-1:0] baud_cnt;
   logic [3:0]        bit_cnt;
   logic              tick;
   logic              last;
   byte_t             shreg;

   assign tick = (baud_cnt == BAUD_W'(BAUD_DIV));
   assign last = tick & (bit_cnt == 4'd8);          // 8 data bits then one stop

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         state    <= TX_IDLE;
         baud_cnt <= '0;
         bit_cnt  <= '0;
      end else begin
         baud_cnt <= (state == TX_IDLE || tick) ? '0 : baud_cnt + 1'b1;
         if (state != TX_SEND) bit_cnt <= '0;
         else if (tick) bit_cnt <= bit_cnt + 1'b1;
         case (state)
            TX_IDLE:  if (i_tx_start) state <= TX_START;   // start ignored while busy
            TX_START: if (tick) state <= TX_SEND;
            default:  if (last) state <= TX_IDLE;
         endcase
      end
   end

   // msb first with ones filling in behind the data for the stop bit
   always_ff @(posedge i_clk) begin
      if (state == TX_IDLE && i_tx_start) shreg <= i_tx_data;
      else if (state == TX_SEND && tick) shreg <= {shreg[6:0], 1'b1};
   end

   assign o_uart_tx = (state == TX_IDLE)  ? 1'b1 :
                      (state == TX_START) ? 1'b0 :
                                            shreg[7];
   assign o_tx_busy = (state != TX_IDLE);

   a_stop_high: assert property (@(posedge i_clk) disable iff (!i_nrst)
      (state == TX_SEND && bit_cnt == 4'd8) |-> o_uart_tx)
      else $error("tx line low during the stop bit");

endmodule

// File: verilog/cpu_datapath.sv
`timescale 1ns/10ps

module cpu_datapath import ice51_pkg::*; (
   input  logic  i_clk,
   input  logic  i_nrst,
   input  logic  i_tx_busy,
   exec_if.dp    exec_bus,
   output logic  o_tx_start,
   output byte_t o_tx_data
);

   byte_t       op;
   byte_t       acc;
   byte_t       acc_next;
   byte_t       regs [8];
   logic [2:0]  r_idx;
   byte_t       r_sel;
   byte_t       r_dec;
   logic [15:0] dptr;
   logic        carry;
   logic [8:0]  sum;
   logic        op_add;
   logic        op_addc;

   assign op      = exec_bus.op;
   assign op_add  = (op == OP_ADD_AI);
   assign op_addc = (op == OP_ADDC_AI);
   assign r_idx   = op[2:0];                      // rn field of the register forms
   assign r_sel   = regs[r_idx];
   assign r_dec   = r_sel - 8'd1;
   assign sum     = {1'b0, acc} + {1'b0, exec_bus.operand} + {8'd0, op_addc & carry};

   //////////////////////////////////////////////////////////////////////
   // accumulator source

   always_comb begin
      acc_next = acc;
      if (op == OP_MOV_AI) acc_next = exec_bus.operand;
      else if (op_add | op_addc) acc_next = sum[7:0];
      else if (op == OP_ANL_AI) acc_next = acc & exec_bus.operand;
      else if (op == OP_XRL_AI) acc_next = acc ^ exec_bus.operand;
      else if (op == OP_INC_A) acc_next = acc + 8'd1;
      else if (op == OP_DEC_A) acc_next = acc - 8'd1;
      else if (op == OP_CLR_A) acc_next = '0;
      else if (op[7:3] == OP_MOV_AR[7:3]) acc_next = r_sel;
      else if (op == OP_MOVX_AD && dptr == ADDR_TX_STAT) acc_next = {7'd0, i_tx_busy};
   end

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         acc   <= '0;
         carry <= 1'b0;
         dptr  <= '0;
         regs  <= '{default: '0};
      end else if (exec_bus.exec) begin
         acc <= acc_next;
         if (op_add | op_addc) carry <= sum[8];   // carry out of bit 7
         if (op == OP_MOV_DPTR) dptr <= {exec_bus.operand, exec_bus.operand2};
         if (op[7:3] == OP_MOV_RA[7:3]) regs[r_idx] <= acc;
         else if (op[7:3] == OP_DJNZ_R[7:3]) regs[r_idx] <= r_dec;
      end
   end

   // status back to the sequencer
   assign exec_bus.acc_zero     = (acc == '0);
   assign exec_bus.carry        = carry;
   assign exec_bus.djnz_nonzero = (r_dec != '0);

   // write to the tx data address kicks off a frame
   assign o_tx_start = exec_bus.exec & (op == OP_MOVX_DA) & (dptr == ADDR_TX_DATA);
   assign o_tx_data  = acc;

endmodule

// File: verilog/cpu_control.sv
`timescale 1ns/10ps

module cpu_control import ice51_pkg::*; (
   input  logic               i_clk,
   input  logic               i_nrst,
   input  logic               i_load_done,
   input  byte_t              i_code_data,
   output logic [CODE_AW-1:0] o_fetch_addr,
   exec_if.ctrl               exec_bus
);

   cpu_state_t         state;
   cpu_state_t         state_next;
   logic [CODE_AW-1:0] pc;
   logic [CODE_AW-1:0] pc_next;
   byte_t              op_q;
   byte_t              op_cur;
   byte_t              operand_q;
   byte_t              operand2_q;
   logic               len2;
   logic               len3;
   logic               taken;

   // opcode is on the code bus in DECODE0 and held after that
   assign op_cur = (state == DECODE0) ? i_code_data : op_q;

   //////////////////////////////////////////////////////////////////////
   // length classes where anything unknown is one byte

   assign len3 = (op_cur == OP_MOV_DPTR);
   assign len2 = (op_cur == OP_MOV_AI) | (op_cur == OP_ADD_AI) |
                 (op_cur == OP_ADDC_AI) | (op_cur == OP_ANL_AI) |
                 (op_cur == OP_XRL_AI) | (op_cur == OP_SJMP) |
                 (op_cur == OP_JZ) | (op_cur == OP_JNZ) |
                 (op_cur == OP_JC) | (op_cur == OP_JNC) |
                 (op_cur[7:3] == OP_DJNZ_R[7:3]);

   // branch decision that only matters in EXECUTE
   assign taken = (op_q == OP_SJMP) |
                  ((op_q == OP_JZ)  &  exec_bus.acc_zero) |
                  ((op_q == OP_JNZ) & ~exec_bus.acc_zero) |
                  ((op_q == OP_JC)  &  exec_bus.carry) |
                  ((op_q == OP_JNC) & ~exec_bus.carry) |
                  ((op_q[7:3] == OP_DJNZ_R[7:3]) & exec_bus.djnz_nonzero);

   always_comb begin
      state_next = state;
      pc_next    = pc;
      case (state)
         FETCH: begin
            if (i_load_done) begin
               state_next = DECODE0;
               pc_next    = pc + 1'b1;
            end
         end
         DECODE0: begin
            state_next = (len2 | len3) ? DECODE1 : EXECUTE;
            if (len2 | len3) pc_next = pc + 1'b1;
         end
         DECODE1: begin
            state_next = len3 ? DECODE2 : EXECUTE;
            if (len3) pc_next = pc + 1'b1;
         end
         DECODE2: state_next = EXECUTE;
         EXECUTE: begin
            state_next = FETCH;
            if (taken) pc_next = pc + CODE_AW'($signed(operand_q));  // pc is next instr
         end
         default: state_next = FETCH;
      endcase
   end

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         state <= FETCH;
         pc    <= '0;
         op_q  <= '0;
      end else begin
         state <= state_next;
         pc    <= pc_next;
         if (state == DECODE0) op_q <= i_code_data;
      end
   end

   always_ff @(posedge i_clk) begin
      if (state == DECODE1) operand_q <= i_code_data;
      if (state == DECODE2) operand2_q <= i_code_data;
   end

   assign o_fetch_addr      = pc;
   assign exec_bus.op       = op_q;
   assign exec_bus.operand  = operand_q;
   assign exec_bus.operand2 = operand2_q;
   assign exec_bus.exec     = (state == EXECUTE);

   a_hold_until_load: assert property (@(posedge i_clk) disable iff (!i_nrst)
      !i_load_done |-> (state == FETCH && pc == '0))
      else $error("core ran before the program was loaded");

endmodule

// File: verilog/uart_loader.sv
`timescale 1ns/10ps

module uart_loader import ice51_pkg::*; (
   input  logic               i_clk,
   input  logic               i_nrst,
   input  logic               i_uart_rx,
   input  logic [CODE_AW-1:0] i_fetch_addr,
   output logic               o_code_wr,
   output logic [CODE_AW-1:0] o_code_addr,
   output byte_t              o_code_data,
   output logic               o_load_done
);

   typedef enum logic [1:0] {RX_IDLE, RX_START, RX_BITS, RX_WAIT} rx_state_t;

   logic [1:0]         rx_sync;
   logic               rx_bit;
   rx_state_t          state;
   logic [BAUD_W-1:0]  bit_cnt;
   logic               half_tick;
   logic               full_tick;
   logic               rx_done;
   byte_t              rx_shift;
   logic [CODE_AW-1:0] byte_cnt;
   logic               load_done;

   assign rx_bit    = rx_sync[1];
   assign half_tick = (bit_cnt == BAUD_W'(BAUD_DIV >> 1));
   assign full_tick = (bit_cnt == BAUD_W'(BAUD_DIV));
   assign rx_done   = (state == RX_WAIT) & full_tick;     // middle of stop bit

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) rx_sync <= 2'b11;                      // idle line is high
      else rx_sync <= {rx_sync[0], i_uart_rx};
   end

   //////////////////////////////////////////////////////////////////////
   // receive fsm

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         state   <= RX_IDLE;
         bit_cnt <= '0;
      end else begin
         bit_cnt <= bit_cnt + 1'b1;
         case (state)
            RX_IDLE: begin
               bit_cnt <= '0;
               if (!rx_bit) state <= RX_START;
            end
            RX_START: begin
               if (half_tick) begin
                  bit_cnt <= '0;
                  state   <= rx_bit ? RX_IDLE : RX_BITS;  // high again means a glitch
               end
            end
            RX_BITS: begin
               if (full_tick) begin
                  bit_cnt <= '0;
                  if (rx_shift[0]) state <= RX_WAIT;      // marker shifts out now
               end
            end
            default: begin
               if (full_tick) begin
                  bit_cnt <= '0;
                  state   <= RX_IDLE;
               end
            end
         endcase
      end
   end

   // lsb first with a marker bit that tells when the byte is complete
   always_ff @(posedge i_clk) begin
      if (state == RX_IDLE && !rx_bit) rx_shift <= 8'h80;
      else if (state == RX_BITS && full_tick) rx_shift <= {rx_bit, rx_shift[7:1]};
   end

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         byte_cnt  <= '0;
         load_done <= 1'b0;
      end else if (o_code_wr) begin
         byte_cnt <= byte_cnt + 1'b1;                     // wraps on the last byte
         if (byte_cnt == CODE_AW'(LOAD_BYTES - 1)) load_done <= 1'b1;
      end
   end

   assign o_code_wr   = rx_done & ~load_done;
   assign o_code_data = rx_shift;
   assign o_code_addr = load_done ? i_fetch_addr : byte_cnt;  // core owns the bus after load
   assign o_load_done = load_done;

   a_wr_pulse: assert property (@(posedge i_clk) disable iff (!i_nrst)
      o_code_wr |=> !o_code_wr)
      else $error("code write held longer than one cycle");

endmodule

// File: verilog/exec_if.sv
`timescale 1ns/10ps

interface exec_if import ice51_pkg::*; ();

   // control to datapath
   byte_t op;                // latched opcode
   byte_t operand;           // first operand byte
   byte_t operand2;          // dpl for mov dptr
   logic  exec;              // high for the EXECUTE cycle only

   // datapath to control, levels
   logic  acc_zero;
   logic  carry;
   logic  djnz_nonzero;      // rn - 1 != 0

   modport ctrl (
      output op, operand, operand2, exec,
      input  acc_zero, carry, djnz_nonzero
   );

   modport dp (
      input  op, operand, operand2, exec,
      output acc_zero, carry, djnz_nonzero
   );

endinterface

// File: verilog/ice51_pkg.sv
package ice51_pkg;

   typedef logic [7:0] byte_t;

   //////////////////////////////////////////////////////////////////////
   // serial timing, code space

   localparam int BAUD_DIV   = 104;                    // last count of the bit timer
   localparam int BAUD_W     = $clog2(BAUD_DIV + 1);
   localparam int CODE_AW    = 9;
   localparam int LOAD_BYTES = 512;                    // bytes before the core runs

   // external space seen through movx
   localparam logic [15:0] ADDR_TX_STAT = 16'h0200;
   localparam logic [15:0] ADDR_TX_DATA = 16'h0201;

   //////////////////////////////////////////////////////////////////////
   // opcodes

   localparam byte_t OP_MOV_AI    = 8'h74;
   localparam byte_t OP_ADD_AI    = 8'h24;
   localparam byte_t OP_ADDC_AI   = 8'h34;
   localparam byte_t OP_ANL_AI    = 8'h54;
   localparam byte_t OP_XRL_AI    = 8'h64;
   localparam byte_t OP_INC_A     = 8'h04;
   localparam byte_t OP_DEC_A     = 8'h14;
   localparam byte_t OP_CLR_A     = 8'hE4;
   localparam byte_t OP_MOV_RA    = 8'hF8;             // low 3 bits pick rn
   localparam byte_t OP_MOV_AR    = 8'hE8;
   localparam byte_t OP_DJNZ_R    = 8'hD8;
   localparam byte_t OP_SJMP      = 8'h80;
   localparam byte_t OP_JZ        = 8'h60;
   localparam byte_t OP_JNZ       = 8'h70;
   localparam byte_t OP_JC        = 8'h40;
   localparam byte_t OP_JNC       = 8'h50;
   localparam byte_t OP_MOV_DPTR  = 8'h90;             // dph first, then dpl
   localparam byte_t OP_MOVX_DA   = 8'hF0;             // movx @dptr,a
   localparam byte_t OP_MOVX_AD   = 8'hE0;             // movx a,@dptr

   // instruction sequencer
   typedef enum logic [2:0] {
      FETCH,
      DECODE0,
      DECODE1,
      DECODE2,
      EXECUTE
   } cpu_state_t;

endpackage
